// File: Makefile
# Verilator build and run of the link training reconfig sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_an_reconfig
RTL_TOP   ?= an_reconfig_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) \
		source/reconfig_regmap_pkg.sv source/reconfig_seq_pkg.sv \
		source/an_handshake.sv source/reconfig_step_seq.sv \
		source/reconfig_step_exec.sv source/an_reconfig_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/an_reconfig_checker.sv
// ######################################
// checker: expected bus traffic,
// handshake rules, error counts
// ######################################

`timescale 1ns/10ps

module an_reconfig_checker #(
	parameter int CHANNEL_W = 8
) (
	input  logic                      clk,
	input  logic                      reset,
	input  reconfig_seq_pkg::av_req_t av_req,
	input  reconfig_seq_pkg::av_rsp_t av_rsp,
	input  logic                      seq_start_rc,
	input  logic                      reconfig_mgmt_busy,
	input  logic                      hdsk_busy_rd,
	input  logic                      hdsk_busy_wr,
	input  logic                      mif_done,
	input  logic                      test_start,  // loads the expected list
	input  logic                      test_end,    // closes the test
	input  logic [1:0]                exp_dis,
	input  logic [CHANNEL_W-1:0]      exp_chan,
	input  logic [31:0]               exp_rom,
	input  int                        exp_polls,
	input  int                        test_num,
	output int                        err_cnt,
	output int                        fail_cnt
);

	logic [38:0]               exp_q[$];  // {address, writedata}
	logic [38:0]               got;
	logic [31:0]               chan_ext;
	reconfig_seq_pkg::av_req_t prev_req;
	logic                      prev_hold;
	logic                      prev_start;
	logic                      prev_mgmt;
	logic                      prev_busy;
	int                        reads;
	int                        writes;
	int                        dones;
	int                        errs_at_start;
	logic                      clear_seen;  // poll read with bit 8 clear done

	// dfe and ctle share a list, only base and offset value differ
	function automatic void push_phase(input logic [6:0] base, input logic [31:0] off);
		exp_q.push_back({base + reconfig_regmap_pkg::REG_LCH, chan_ext});
		exp_q.push_back({base + reconfig_regmap_pkg::REG_OFFSET, off});
		exp_q.push_back({base + reconfig_regmap_pkg::REG_DATA, 32'h0});
		exp_q.push_back({base + reconfig_regmap_pkg::REG_STATUS, 32'h1});
	endfunction

	function automatic void push_mif();
		logic [6:0] b;
		b = reconfig_regmap_pkg::MIF_BASE;
		exp_q.push_back({b + reconfig_regmap_pkg::REG_LCH, chan_ext});
		exp_q.push_back({b + reconfig_regmap_pkg::REG_STATUS, 32'h0});
		exp_q.push_back({b + reconfig_regmap_pkg::REG_OFFSET, 32'h0});
		exp_q.push_back({b + reconfig_regmap_pkg::REG_DATA, exp_rom});
		exp_q.push_back({b + reconfig_regmap_pkg::REG_STATUS, 32'h1});
		exp_q.push_back({b + reconfig_regmap_pkg::REG_OFFSET, 32'h1});  // after poll
		exp_q.push_back({b + reconfig_regmap_pkg::REG_DATA, 32'h1});
		exp_q.push_back({b + reconfig_regmap_pkg::REG_STATUS, 32'h1});  // stream start
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			err_cnt    = 0;
			fail_cnt   = 0;
			prev_hold  = 1'b0;
			prev_start = 1'b0;
			prev_mgmt  = 1'b0;
			prev_busy  = 1'b0;
		end else begin
			if (av_req.write && av_req.read) begin
				$display("write and read both high at %0t ns", $time);
				err_cnt++;
			end
			if (prev_hold && av_req !== prev_req) begin
				$display("** Error at %0t ns: av_req expected %h got %h", $time, prev_req, av_req);
				err_cnt++;
			end
			if (hdsk_busy_rd !== hdsk_busy_wr) begin
				$display("** Error at %0t ns: hdsk_busy_wr expected %b got %b",
					$time, hdsk_busy_rd, hdsk_busy_wr);
				err_cnt++;
			end
			// acceptance of a request seen on the last edge
			if (prev_start && !prev_busy && !prev_mgmt && !hdsk_busy_rd) begin
				$display("request with mgmt busy low was not accepted at %0t ns", $time);
				err_cnt++;
			end
			if (prev_start && !prev_busy && prev_mgmt && hdsk_busy_rd) begin
				$display("request was accepted while mgmt busy was high at %0t ns", $time);
				err_cnt++;
			end
			if (test_start) begin
				exp_q.delete();
				chan_ext = '0;
				chan_ext[CHANNEL_W-1:0] = exp_chan;
				if (exp_dis[0])
					push_phase(reconfig_regmap_pkg::DFE_BASE, 32'h0);
				if (exp_dis[1])
					push_phase(reconfig_regmap_pkg::ANALOG_BASE, reconfig_regmap_pkg::CTLE_OFFSET_VAL);
				push_mif();
				reads         = 0;
				writes        = 0;
				dones         = 0;
				clear_seen    = 1'b0;
				errs_at_start = err_cnt;
			end
			if (av_req.write && !av_rsp.waitrequest) begin
				got = {av_req.address, av_req.writedata};
				writes++;
				if (exp_q.size() == 0) begin
					$display("unexpected write to %h at %0t ns", av_req.address, $time);
					err_cnt++;
				end else if (got !== exp_q[0]) begin
					$display("** Error at %0t ns: {av_req.address, av_req.writedata} expected %h got %h",
						$time, exp_q[0], got);
					err_cnt++;
					void'(exp_q.pop_front());
				end else begin
					void'(exp_q.pop_front());
				end
				if (got == {reconfig_regmap_pkg::MIF_BASE + reconfig_regmap_pkg::REG_OFFSET, 32'h1}
					&& !clear_seen) begin
					$display("mif offset write completed before the poll cleared at %0t ns", $time);
					err_cnt++;
				end
			end
			if (av_req.read && !av_rsp.waitrequest) begin
				reads++;
				if (av_req.address !== reconfig_regmap_pkg::MIF_BASE + reconfig_regmap_pkg::REG_STATUS) begin
					$display("** Error at %0t ns: av_req.address expected %h got %h", $time,
						reconfig_regmap_pkg::MIF_BASE + reconfig_regmap_pkg::REG_STATUS, av_req.address);
					err_cnt++;
				end
				if (!av_rsp.readdata[reconfig_regmap_pkg::MIF_BUSY_BIT])
					clear_seen = 1'b1;
			end
			if (mif_done)
				dones++;
			if (test_end) begin
				if (exp_q.size() != 0) begin
					$display("%0d expected writes never completed", exp_q.size());
					err_cnt++;
				end
				if (reads != exp_polls + 1) begin
					$display("** Error at %0t ns: status reads expected %0d got %0d",
						$time, exp_polls + 1, reads);
					err_cnt++;
				end
				if (dones != 1) begin
					$display("** Error at %0t ns: mif_done pulses expected 1 got %0d", $time, dones);
					err_cnt++;
				end
				if (err_cnt != errs_at_start)
					fail_cnt++;
				$display("test %0d disable=%0d writes=%0d reads=%0d : %s", test_num, exp_dis,
					writes, reads, (err_cnt == errs_at_start) ? "pass" : "fail");
			end
			prev_hold  = (av_req.write || av_req.read) && av_rsp.waitrequest;
			prev_req   = av_req;
			prev_start = seq_start_rc;
			prev_mgmt  = reconfig_mgmt_busy;
			prev_busy  = hdsk_busy_rd;
		end
	end

endmodule

// File: bench/an_reconfig_tests.txt
# disable(hex) channel(hex) rom_address(hex) poll_count busy_delay max_stall
# disable bit 0 runs dfe, bit 1 runs ctle, mif always runs
0 00 00000000 0 1 1
0 05 00001000 2 3 2
1 0a 00002040 1 2 3
2 1f 0000abcd 3 4 1
3 7e 12345678 0 1 4
3 ff 00000100 4 5 2
1 01 deadbeef 2 2 5
2 33 00000010 1 6 3
0 80 cafe0000 5 1 2
3 42 0000ffff 2 3 1
0 11 00000200 0 8 6
3 03 80000001 6 2 3

// File: bench/tb_an_reconfig.sv
// ######################################
// testbench top with clock, reset, test
// file reader, stimulus, controller model
// ######################################

`timescale 1ns/10ps

module tb_an_reconfig;

	localparam int CHANNEL_W = 8;
	localparam int MAX_TESTS = 32;
	localparam int BUSY_HOLD = 6;  // cycles mgmt busy stays up

	logic                      clk;
	logic                      reset;
	reconfig_seq_pkg::av_req_t av_req;
	reconfig_seq_pkg::av_rsp_t av_rsp;
	logic [CHANNEL_W-1:0]      logical_channel_number;
	logic [31:0]               mif_rom_address;
	logic [1:0]                disable_before_an;
	logic                      seq_start_rc;
	logic                      reconfig_mgmt_busy;
	logic                      hdsk_busy_rd;
	logic                      hdsk_busy_wr;
	logic                      mif_done;

	// test table filled from the tests file
	logic [1:0]           t_dis[MAX_TESTS];
	logic [CHANNEL_W-1:0] t_chan[MAX_TESTS];
	logic [31:0]          t_rom[MAX_TESTS];
	int                   t_polls[MAX_TESTS];
	int                   t_dly[MAX_TESTS];
	int                   t_stall[MAX_TESTS];
	int                   n_tests;
	bit                   loaded;
	int                   tb_errs;

	// controller model config and state
	logic        test_start;
	logic        test_end;
	int          test_num;
	int          cur_polls;
	int          cur_dly;
	int          cur_stall;
	logic        force_busy;  // holds mgmt busy high on its own
	int          polls_left;
	int          stall_cnt;
	logic        armed;
	int          dly_cnt;
	int          hold_cnt;
	logic [31:0] rnd_state;
	int          err_cnt;
	int          fail_cnt;

	an_reconfig_top #(
		.CHANNEL_W (CHANNEL_W)
	) u_an_reconfig_top (
		.clk                    (clk),
		.reset                  (reset),
		.av_req                 (av_req),
		.av_rsp                 (av_rsp),
		.logical_channel_number (logical_channel_number),
		.mif_rom_address        (mif_rom_address),
		.disable_before_an      (disable_before_an),
		.seq_start_rc           (seq_start_rc),
		.reconfig_mgmt_busy     (reconfig_mgmt_busy),
		.hdsk_busy_rd           (hdsk_busy_rd),
		.hdsk_busy_wr           (hdsk_busy_wr),
		.mif_done               (mif_done)
	);

	an_reconfig_checker #(
		.CHANNEL_W (CHANNEL_W)
	) u_checker (
		.clk                (clk),
		.reset              (reset),
		.av_req             (av_req),
		.av_rsp             (av_rsp),
		.seq_start_rc       (seq_start_rc),
		.reconfig_mgmt_busy (reconfig_mgmt_busy),
		.hdsk_busy_rd       (hdsk_busy_rd),
		.hdsk_busy_wr       (hdsk_busy_wr),
		.mif_done           (mif_done),
		.test_start         (test_start),
		.test_end           (test_end),
		.exp_dis            (disable_before_an),
		.exp_chan           (logical_channel_number),
		.exp_rom            (mif_rom_address),
		.exp_polls          (cur_polls),
		.test_num           (test_num),
		.err_cnt            (err_cnt),
		.fail_cnt           (fail_cnt)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	// reconfiguration controller model with stalls, poll data and mgmt busy
	initial begin
		av_rsp             = '{readdata: 32'h0, waitrequest: 1'b1};
		reconfig_mgmt_busy = 1'b0;
		rnd_state          = 32'hb507;
		polls_left         = 0;
		stall_cnt          = 0;
		armed              = 1'b0;
		dly_cnt            = 0;
		hold_cnt           = 0;
		forever begin
			@(posedge clk);
			if (reset) begin
				av_rsp.waitrequest <= 1'b1;
				reconfig_mgmt_busy <= 1'b0;
				armed              <= 1'b0;
				dly_cnt            <= 0;
				hold_cnt           <= 0;
			end else begin
				if (test_start) begin
					polls_left      <= cur_polls;
					av_rsp.readdata <= (cur_polls > 0) ? 32'h100 : 32'h0;
				end
				if ((av_req.write || av_req.read) && !av_rsp.waitrequest) begin
					// access completes on this edge
					av_rsp.waitrequest <= 1'b1;
					armed              <= 1'b0;
					if (av_req.read && polls_left > 0) begin
						polls_left      <= polls_left - 1;
						av_rsp.readdata <= (polls_left > 1) ? 32'h100 : 32'h0;
					end
					if (av_req.write && av_req.writedata == 32'd1 && av_req.address[2:0] == 3'd2)
						dly_cnt <= cur_dly;  // start write to a status register
				end else if (av_req.write || av_req.read) begin
					if (!armed) begin
						armed     <= 1'b1;
						rnd_state = xorshift32(rnd_state);
						stall_cnt = int'(rnd_state % cur_stall);
						if (stall_cnt == 0)
							av_rsp.waitrequest <= 1'b0;
					end else if (stall_cnt <= 1) begin
						stall_cnt = 0;
						av_rsp.waitrequest <= 1'b0;
					end else begin
						stall_cnt = stall_cnt - 1;
					end
				end
				if (dly_cnt == 1)
					hold_cnt <= BUSY_HOLD;
				else if (hold_cnt != 0)
					hold_cnt <= hold_cnt - 1;
				if (dly_cnt != 0 && !((av_req.write || av_req.read) && !av_rsp.waitrequest))
					dly_cnt <= dly_cnt - 1;
				reconfig_mgmt_busy <= force_busy || (hold_cnt != 0);
			end
		end
	end

	task automatic load_tests();
		int                   fd;
		int                   r;
		string                line;
		logic [1:0]           d;
		logic [CHANNEL_W-1:0] ch;
		logic [31:0]          rom;
		int                   p;
		int                   dl;
		int                   st;
		n_tests = 0;
		fd = $fopen("bench/an_reconfig_tests.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				r = $fgets(line, fd);
				if (r > 0 && line.substr(0, 0) != "#") begin
					r = $sscanf(line, "%h %h %h %d %d %d", d, ch, rom, p, dl, st);
					if (r == 6 && n_tests < MAX_TESTS) begin
						t_dis[n_tests]   = d;
						t_chan[n_tests]  = ch;
						t_rom[n_tests]   = rom;
						t_polls[n_tests] = p;
						t_dly[n_tests]   = dl;
						t_stall[n_tests] = (st < 1) ? 1 : st;
						n_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, got);
			tb_errs++;
		end
	endtask

	// request held while mgmt busy is high must be ignored
	task automatic blocked_request();
		force_busy <= 1'b1;
		repeat (3) @(posedge clk);
		seq_start_rc <= 1'b1;
		repeat (6) begin
			@(posedge clk);
			expect_bit("hdsk_busy_rd", hdsk_busy_rd, 1'b0);
		end
		seq_start_rc <= 1'b0;
		force_busy   <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic run_test(input int i);
		@(posedge clk);
		while (reconfig_mgmt_busy)
			@(posedge clk);
		cur_polls  <= t_polls[i];
		cur_dly    <= t_dly[i];
		cur_stall  <= t_stall[i];
		test_num   <= i;
		disable_before_an      <= t_dis[i];
		logical_channel_number <= t_chan[i];
		mif_rom_address        <= t_rom[i];
		test_start <= 1'b1;
		@(posedge clk);
		test_start   <= 1'b0;
		seq_start_rc <= 1'b1;
		@(posedge clk);
		while (!hdsk_busy_rd)
			@(posedge clk);
		while (!mif_done)
			@(posedge clk);
		repeat (3) begin
			@(posedge clk);
			expect_bit("hdsk_busy_rd", hdsk_busy_rd, 1'b1);  // request still held
		end
		seq_start_rc <= 1'b0;
		repeat (2) @(posedge clk);
		expect_bit("hdsk_busy_rd", hdsk_busy_rd, 1'b0);
		expect_bit("hdsk_busy_wr", hdsk_busy_wr, 1'b0);
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
		@(posedge clk);
	endtask

	// watchdog limit grows with the delays of every test
	initial begin
		int limit;
		wait (loaded);
		limit = 200;
		for (int i = 0; i < n_tests; i++)
			limit += 30 * (t_stall[i] + 4) + (t_polls[i] + 1) * (t_stall[i] + 2)
				+ 3 * (t_dly[i] + BUSY_HOLD + 10) + 60;
		#(limit * 4);
		$display("watchdog: run did not finish within %0d ns", limit * 4);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		reset                  = 1'b1;
		seq_start_rc           = 1'b0;
		disable_before_an      = 2'b00;
		logical_channel_number = '0;
		mif_rom_address        = 32'h0;
		test_start             = 1'b0;
		test_end               = 1'b0;
		test_num               = 0;
		cur_polls              = 0;
		cur_dly                = 1;
		cur_stall              = 1;
		force_busy             = 1'b0;
		tb_errs                = 0;
		load_tests();
		loaded = 1'b1;
		if (n_tests == 0) begin
			$display("no tests could be read from bench/an_reconfig_tests.txt");
			$display("ERRORS FOUND");
			$finish;
		end else begin
			repeat (16) @(posedge clk);
			reset <= 1'b0;
			@(posedge clk);
			// control outputs right after reset
			expect_bit("av_req.write", av_req.write, 1'b0);
			expect_bit("av_req.read", av_req.read, 1'b0);
			expect_bit("hdsk_busy_rd", hdsk_busy_rd, 1'b0);
			expect_bit("hdsk_busy_wr", hdsk_busy_wr, 1'b0);
			expect_bit("mif_done", mif_done, 1'b0);
			blocked_request();
			for (int i = 0; i < n_tests; i++)
				run_test(i);
			$display("tests %0d, failed %0d, errors %0d", n_tests, fail_cnt, err_cnt + tb_errs);
			if (err_cnt + tb_errs == 0 && fail_cnt == 0) begin
				$display("NO ERRORS");
			end else begin
				$display("ERRORS FOUND");
			end
			$finish;
		end
	end

endmodule

// File: source/an_handshake.sv
// ######################################
// request / busy / done handshake
// towards the link training processor
// ######################################

`timescale 1ns/10ps

module an_handshake (
	input  logic clk,
	input  logic reset,
	input  logic seq_start_rc,        // request level from the processor
	input  logic reconfig_mgmt_busy,
	input  logic seq_done,            // step sequencer finished
	output logic run_start,
	output logic hdsk_busy_rd,
	output logic hdsk_busy_wr,
	output logic mif_done
);

	typedef enum logic [1:0] {
		HS_IDLE,     // waiting for a request
		HS_RUN,      // steps in progress
		HS_DONE,     // mif_done high
		HS_RELEASE   // hold busy until the request drops
	} hs_state_e;

	hs_state_e state_q;
	logic      busy_q;  // drives both busy outputs

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q   <= HS_IDLE;
			busy_q    <= 1'b0;
			run_start <= 1'b0;
		end else begin
			run_start <= 1'b0;  // pulse
			case (state_q)
				HS_IDLE: begin
					// controller must be quiet before a new sequence
					if (seq_start_rc && !reconfig_mgmt_busy) begin
						state_q   <= HS_RUN;
						busy_q    <= 1'b1;
						run_start <= 1'b1;
					end
				end
				HS_RUN: begin
					if (seq_done) begin
						state_q <= HS_DONE;
					end
				end
				HS_DONE: begin
					state_q <= HS_RELEASE;  // done lasts exactly one cycle
				end
				HS_RELEASE: begin
					if (!seq_start_rc) begin
						state_q <= HS_IDLE;
						busy_q  <= 1'b0;
					end
				end
			endcase
		end
	end

	assign mif_done     = (state_q == HS_DONE);
	assign hdsk_busy_rd = busy_q;
	assign hdsk_busy_wr = busy_q;

	// done only inside the busy window
	assert property (@(posedge clk) disable iff (reset) mif_done |-> busy_q);

endmodule

// File: source/an_reconfig_top.sv
// ######################################
// link training reconfig sequencer top
// handshake, step sequencer, executor
// ######################################

`timescale 1ns/10ps

module an_reconfig_top #(
	parameter int CHANNEL_W = 8
) (
	input  logic                                      clk,
	input  logic                                      reset,
	// reconfiguration controller management bus
	output reconfig_seq_pkg::av_req_t                 av_req,
	input  reconfig_seq_pkg::av_rsp_t                 av_rsp,
	// levels, sampled when a request is accepted
	input  logic [CHANNEL_W-1:0]                      logical_channel_number,
	input  logic [reconfig_regmap_pkg::AV_DATA_W-1:0] mif_rom_address,
	input  logic [1:0]                                disable_before_an,  // [1] ctle, [0] dfe
	// handshake with the link training processor
	input  logic                                      seq_start_rc,
	input  logic                                      reconfig_mgmt_busy,
	output logic                                      hdsk_busy_rd,
	output logic                                      hdsk_busy_wr,
	output logic                                      mif_done
);

	logic                      run_start;  // one cycle, sequence kick
	logic                      seq_done;   // one cycle, last step finished
	reconfig_seq_pkg::step_t   step;
	logic                      step_valid;
	logic                      step_done;

	an_handshake u_an_handshake (
		.clk                (clk),
		.reset              (reset),
		.seq_start_rc       (seq_start_rc),
		.reconfig_mgmt_busy (reconfig_mgmt_busy),
		.seq_done           (seq_done),
		.run_start          (run_start),
		.hdsk_busy_rd       (hdsk_busy_rd),
		.hdsk_busy_wr       (hdsk_busy_wr),
		.mif_done           (mif_done)
	);

	reconfig_step_seq #(
		.CHANNEL_W (CHANNEL_W)
	) u_reconfig_step_seq (
		.clk                    (clk),
		.reset                  (reset),
		.run_start              (run_start),
		.logical_channel_number (logical_channel_number),
		.mif_rom_address        (mif_rom_address),
		.disable_before_an      (disable_before_an),
		.step                   (step),
		.step_valid             (step_valid),
		.step_done              (step_done),
		.seq_done               (seq_done)
	);

	reconfig_step_exec u_reconfig_step_exec (
		.clk                (clk),
		.reset              (reset),
		.step               (step),
		.step_valid         (step_valid),
		.step_done          (step_done),
		.av_req             (av_req),
		.av_rsp             (av_rsp),
		.reconfig_mgmt_busy (reconfig_mgmt_busy)
	);

endmodule

// File: source/reconfig_regmap_pkg.sv
// ######################################
// register map of the transceiver
// reconfiguration controller
// ######################################

package reconfig_regmap_pkg;

	// avalon-mm management bus
	localparam int AV_ADDR_W = 7;
	localparam int AV_DATA_W = 32;

	// block bases in the controller address space
	localparam logic [AV_ADDR_W-1:0] ANALOG_BASE = 7'h08;  // pma analog controls
	localparam logic [AV_ADDR_W-1:0] DFE_BASE    = 7'h28;  // decision feedback equalizer
	localparam logic [AV_ADDR_W-1:0] MIF_BASE    = 7'h38;  // mif streamer

	// register offsets, identical in every block
	localparam logic [AV_ADDR_W-1:0] REG_LCH    = 7'd0;  // logical channel select
	localparam logic [AV_ADDR_W-1:0] REG_STATUS = 7'd2;  // control and status
	localparam logic [AV_ADDR_W-1:0] REG_OFFSET = 7'd3;  // internal register offset
	localparam logic [AV_ADDR_W-1:0] REG_DATA   = 7'd4;  // internal register data

	// self clears once the streamer has taken the rom address
	localparam int MIF_BUSY_BIT = 8;

	// analog internal offset of the ctle manual setting
	localparam logic [AV_DATA_W-1:0] CTLE_OFFSET_VAL = 32'h0000_0011;

endpackage

// File: source/reconfig_seq_pkg.sv
// ######################################
// step kinds, step and bus structs,
// phase codes of the reconfig sequencer
// ######################################

package reconfig_seq_pkg;

	// what the executor does with one step
	typedef enum logic [1:0] {
		STEP_WRITE     = 2'd0,  // single held write
		STEP_POLL      = 2'd1,  // reads until mif busy bit is clear
		STEP_WAIT_HIGH = 2'd2,  // no bus access, wait for mgmt busy high
		STEP_WAIT_LOW  = 2'd3   // no bus access, wait for mgmt busy low
	} step_kind_e;

	// one entry of a phase step list
	typedef struct packed {
		step_kind_e                                kind;
		logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] addr;
		logic [reconfig_regmap_pkg::AV_DATA_W-1:0] data;  // ignored by polls and waits
	} step_t;

	// master side of the management bus
	typedef struct packed {
		logic                                      write;
		logic                                      read;
		logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] address;
		logic [reconfig_regmap_pkg::AV_DATA_W-1:0] writedata;
	} av_req_t;

	// slave side, readdata valid when waitrequest is low
	typedef struct packed {
		logic [reconfig_regmap_pkg::AV_DATA_W-1:0] readdata;
		logic                                      waitrequest;
	} av_rsp_t;

	// phases run in this order
	typedef enum logic [1:0] {
		PH_DFE  = 2'd0,  // switch dfe off
		PH_CTLE = 2'd1,  // zero the ctle manual value
		PH_MIF  = 2'd2   // stream the mif, always runs
	} phase_e;

endpackage

// File: source/reconfig_step_exec.sv
// ######################################
// step executor, held bus accesses,
// status polls and mgmt busy waits
// ######################################

`timescale 1ns/10ps

module reconfig_step_exec (
	input  logic                      clk,
	input  logic                      reset,
	input  reconfig_seq_pkg::step_t   step,        // stable while step_valid
	input  logic                      step_valid,
	output logic                      step_done,
	output reconfig_seq_pkg::av_req_t av_req,
	input  reconfig_seq_pkg::av_rsp_t av_rsp,
	input  logic                      reconfig_mgmt_busy
);

	typedef enum logic [1:0] {
		EX_IDLE,    // waiting for a step
		EX_ACCESS,  // write or read held on the bus
		EX_LEVEL,   // waiting on mgmt busy
		EX_DONE     // step_done pulse
	} ex_state_e;

	ex_state_e                                 state_q;
	logic                                      wr_q;
	logic                                      rd_q;
	logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] addr_q;
	logic [reconfig_regmap_pkg::AV_DATA_W-1:0] data_q;
	logic                                      poll_busy;  // read came back with bit 8 set
	logic                                      level_hit;

	assign poll_busy = rd_q && av_rsp.readdata[reconfig_regmap_pkg::MIF_BUSY_BIT];
	assign level_hit = reconfig_mgmt_busy == (step.kind == reconfig_seq_pkg::STEP_WAIT_HIGH);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= EX_IDLE;
			wr_q    <= 1'b0;
			rd_q    <= 1'b0;
		end else begin
			case (state_q)
				EX_IDLE: begin
					if (step_valid) begin
						case (step.kind)
							reconfig_seq_pkg::STEP_WRITE: begin
								wr_q    <= 1'b1;
								state_q <= EX_ACCESS;
							end
							reconfig_seq_pkg::STEP_POLL: begin
								rd_q    <= 1'b1;
								state_q <= EX_ACCESS;
							end
							default: state_q <= EX_LEVEL;  // waits never touch the bus
						endcase
					end
				end
				EX_ACCESS: begin
					// a busy poll result keeps read high, next read follows directly
					if (!av_rsp.waitrequest && !poll_busy) begin
						wr_q    <= 1'b0;
						rd_q    <= 1'b0;
						state_q <= EX_DONE;
					end
				end
				EX_LEVEL: begin
					if (level_hit) begin
						state_q <= EX_DONE;
					end
				end
				EX_DONE: begin
					state_q <= EX_IDLE;  // sequencer drops valid meanwhile
				end
			endcase
		end
	end

	// address and data only load at step entry
	always_ff @(posedge clk) begin
		if (state_q == EX_IDLE && step_valid) begin
			addr_q <= step.addr;
			data_q <= step.data;
		end
	end

	assign step_done = (state_q == EX_DONE);
	assign av_req    = '{write: wr_q, read: rd_q, address: addr_q, writedata: data_q};

	// back pressure freezes the whole request
	assert property (@(posedge clk) disable iff (reset)
		(av_req.write || av_req.read) && av_rsp.waitrequest |=> $stable(av_req));

	assert property (@(posedge clk) disable iff (reset) !(av_req.write && av_req.read));

endmodule

// File: source/reconfig_step_seq.sv
// ######################################
// phase selection and step lists
// for dfe, ctle and mif reconfiguration
// ######################################

`timescale 1ns/10ps

module reconfig_step_seq #(
	parameter int CHANNEL_W = 8
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      run_start,
	input  logic [CHANNEL_W-1:0]                      logical_channel_number,
	input  logic [reconfig_regmap_pkg::AV_DATA_W-1:0] mif_rom_address,
	input  logic [1:0]                                disable_before_an,  // [1] ctle, [0] dfe
	output reconfig_seq_pkg::step_t                   step,
	output logic                                      step_valid,
	input  logic                                      step_done,
	output logic                                      seq_done
);

	logic [CHANNEL_W-1:0]                      chan_q;
	logic [reconfig_regmap_pkg::AV_DATA_W-1:0] rom_q;
	logic                                      ctle_en_q;  // ctle phase follows dfe
	logic [reconfig_regmap_pkg::AV_DATA_W-1:0] chan_ext;   // channel zero extended
	logic [reconfig_regmap_pkg::AV_DATA_W-1:0] off_val;
	logic                                      active_q;
	reconfig_seq_pkg::phase_e                  phase_q;
	logic [3:0]                                idx_q;      // step within the phase
	logic                                      last_step;
	logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] base;
	logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] a_lch;
	logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] a_sts;
	logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] a_off;
	logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] a_dat;

	function automatic reconfig_seq_pkg::step_t mk_step(
		input reconfig_seq_pkg::step_kind_e        kind,
		input logic [reconfig_regmap_pkg::AV_ADDR_W-1:0] addr,
		input logic [reconfig_regmap_pkg::AV_DATA_W-1:0] data
	);
		return '{kind: kind, addr: addr, data: data};
	endfunction

	// request levels taken once per sequence
	always_ff @(posedge clk) begin
		if (run_start) begin
			chan_q    <= logical_channel_number;
			rom_q     <= mif_rom_address;
			ctle_en_q <= disable_before_an[1];
		end
	end

	assign last_step = (phase_q == reconfig_seq_pkg::PH_MIF) ? (idx_q == 4'd10) : (idx_q == 4'd5);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active_q   <= 1'b0;
			phase_q    <= reconfig_seq_pkg::PH_DFE;
			idx_q      <= '0;
			step_valid <= 1'b0;
			seq_done   <= 1'b0;
		end else begin
			seq_done <= 1'b0;
			if (run_start) begin
				active_q   <= 1'b1;
				step_valid <= 1'b1;
				idx_q      <= '0;
				if (disable_before_an[0])
					phase_q <= reconfig_seq_pkg::PH_DFE;
				else if (disable_before_an[1])
					phase_q <= reconfig_seq_pkg::PH_CTLE;
				else
					phase_q <= reconfig_seq_pkg::PH_MIF;
			end else if (step_valid && step_done) begin
				step_valid <= 1'b0;  // one gap cycle between steps
				idx_q      <= idx_q + 4'd1;
				if (last_step) begin
					idx_q <= '0;
					case (phase_q)
						reconfig_seq_pkg::PH_DFE:
							phase_q <= ctle_en_q ? reconfig_seq_pkg::PH_CTLE
								: reconfig_seq_pkg::PH_MIF;
						reconfig_seq_pkg::PH_CTLE:
							phase_q <= reconfig_seq_pkg::PH_MIF;
						default: begin  // mif was the last phase
							active_q <= 1'b0;
							seq_done <= 1'b1;
						end
					endcase
				end
			end else if (active_q && !step_valid) begin
				step_valid <= 1'b1;  // present next step
			end
		end
	end

	always_comb begin
		chan_ext                = '0;
		chan_ext[CHANNEL_W-1:0] = chan_q;
	end

	always_comb begin
		case (phase_q)
			reconfig_seq_pkg::PH_DFE:  base = reconfig_regmap_pkg::DFE_BASE;
			reconfig_seq_pkg::PH_CTLE: base = reconfig_regmap_pkg::ANALOG_BASE;
			default:                   base = reconfig_regmap_pkg::MIF_BASE;
		endcase
		a_lch   = base + reconfig_regmap_pkg::REG_LCH;
		a_sts   = base + reconfig_regmap_pkg::REG_STATUS;
		a_off   = base + reconfig_regmap_pkg::REG_OFFSET;
		a_dat   = base + reconfig_regmap_pkg::REG_DATA;
		off_val = (phase_q == reconfig_seq_pkg::PH_CTLE) ?
			reconfig_regmap_pkg::CTLE_OFFSET_VAL : '0;
	end

	// step lists
	always_comb begin
		if (phase_q == reconfig_seq_pkg::PH_MIF) begin
			case (idx_q)
				4'd0:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_lch, chan_ext);
				4'd1:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_sts, '0);  // mif_mode 0
				4'd2:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_off, '0);
				4'd3:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_dat, rom_q);
				4'd4:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_sts, 32'd1);
				4'd5:    step = mk_step(reconfig_seq_pkg::STEP_POLL, a_sts, '0);
				4'd6:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_off, 32'd1);
				4'd7:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_dat, 32'd1);
				4'd8:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_sts, 32'd1);  // start stream
				4'd9:    step = mk_step(reconfig_seq_pkg::STEP_WAIT_HIGH, a_sts, '0);
				default: step = mk_step(reconfig_seq_pkg::STEP_WAIT_LOW, a_sts, '0);
			endcase
		end else begin
			// dfe and ctle share one list with their own base and offset
			case (idx_q)
				4'd0:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_lch, chan_ext);
				4'd1:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_off, off_val);
				4'd2:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_dat, '0);  // off / zero
				4'd3:    step = mk_step(reconfig_seq_pkg::STEP_WRITE, a_sts, 32'd1);
				4'd4:    step = mk_step(reconfig_seq_pkg::STEP_WAIT_HIGH, a_sts, '0);
				default: step = mk_step(reconfig_seq_pkg::STEP_WAIT_LOW, a_sts, '0);
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) !active_q |-> !step_valid);

endmodule

// File: tb.f
source/reconfig_regmap_pkg.sv
source/reconfig_seq_pkg.sv
source/an_handshake.sv
source/reconfig_step_seq.sv
source/reconfig_step_exec.sv
source/an_reconfig_top.sv
bench/an_reconfig_checker.sv
bench/tb_an_reconfig.sv
